// File: common/afifo_pkg.sv
// Shared widths, depth, flag margins and packed types for the dual-clock FIFO
// Every RTL block of the FIFO pulls these in with a wildcard import
// Depth must stay even so the Johnson pointer has 2*FIFO_DEPTH states

`default_nettype none

package afifo_pkg;

        // ------------------------------------------------------------
        // Sizes
        // ------------------------------------------------------------
        localparam int FIFO_DEPTH       = 10;
        localparam int DATA_W           = 8;
        localparam int ADDR_W           = $clog2(FIFO_DEPTH);
        // Extra bit is the wrap flag
        localparam int PTR_W            = ADDR_W + 1;
        // One Johnson bit per entry
        localparam int JC_W             = FIFO_DEPTH;
        localparam int SYNC_STAGES      = 2;
        // Almost-full asserts this many entries before full
        localparam int ALMOST_WR_MARGIN = 2;
        // Almost-empty asserts at or below this fill level
        localparam int ALMOST_RD_MARGIN = 2;

        // ------------------------------------------------------------
        // Types
        // ------------------------------------------------------------
        typedef logic [DATA_W-1:0] data_t;
        typedef logic [ADDR_W-1:0] addr_t;
        typedef logic [JC_W-1:0]   ptr_jc_t;

        // Address counts 0..FIFO_DEPTH-1, wrap toggles on each pass
        typedef struct packed {
                logic  wrap;
                addr_t addr;
        } ptr_bin_t;

        typedef struct packed {
                logic  req;
                data_t data;
        } wr_req_t;

        typedef struct packed {
                logic full;
                logic almost_full;
        } wr_status_t;

        typedef struct packed {
                logic empty;
                logic almost_empty;
        } rd_status_t;

        // Entries between two binary pointers
        // Differing wrap flags mean the write side is one pass ahead
        function automatic logic [PTR_W-1:0] fill_level(input ptr_bin_t wr_ptr,
                                                        input ptr_bin_t rd_ptr);
                logic [PTR_W-1:0] wa;
                logic [PTR_W-1:0] ra;
                wa = PTR_W'(wr_ptr.addr);
                ra = PTR_W'(rd_ptr.addr);
                if (wr_ptr.wrap == rd_ptr.wrap) begin
                        return wa - ra;
                end
                return wa + PTR_W'(FIFO_DEPTH) - ra;
        endfunction

endpackage

`default_nettype wire

// File: ctrl/afifo_ptr_cnt.sv
// Paired binary and Johnson pointer for one side of the FIFO
// Both advance together on i_en and read zero after reset
// o_bin_next is the value the pointer takes at the coming edge

`default_nettype none

module afifo_ptr_cnt
        import afifo_pkg::*;
(
        input  wire      i_clk,
        input  wire      i_rst_n,
        input  wire      i_en,
        output ptr_bin_t o_bin,
        output ptr_bin_t o_bin_next,
        output ptr_jc_t  o_jc
);

        ptr_bin_t bin_q;
        ptr_bin_t bin_next;
        ptr_jc_t  jc_q;
        ptr_jc_t  jc_next;

        // ------------------------------------------------------------
        // Next-state logic
        // ------------------------------------------------------------
        always_comb begin
                bin_next = bin_q;
                if (i_en) begin
                        // Address wraps at FIFO_DEPTH, not at a power of two
                        if (bin_q.addr == addr_t'(FIFO_DEPTH - 1)) begin
                                bin_next.addr = '0;
                                bin_next.wrap = ~bin_q.wrap;
                        end else begin
                                bin_next.addr = bin_q.addr + 1'b1;
                        end
                end
        end

        // Shift in the inverse of the top bit, one bit flips per step
        assign jc_next = i_en ? {jc_q[JC_W-2:0], ~jc_q[JC_W-1]} : jc_q;

        // ------------------------------------------------------------
        // Pointer registers
        // ------------------------------------------------------------
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        bin_q <= '0;
                        jc_q  <= '0;
                end else begin
                        bin_q <= bin_next;
                        jc_q  <= jc_next;
                end
        end

        assign o_bin      = bin_q;
        assign o_bin_next = bin_next;
        assign o_jc       = jc_q;

endmodule

`default_nettype wire

// File: ctrl/afifo_wr_ctrl.sv
// Write-domain controller
// Accepts writes while not full and drives the storage write port
// Full and almost-full are registered from the next write pointer

`default_nettype none

module afifo_wr_ctrl
        import afifo_pkg::*;
(
        input  wire        wr_clk,
        input  wire        wr_rst_n,
        input  wr_req_t    i_wr_req,
        input  ptr_bin_t   i_rd_ptr,
        output wr_status_t o_wr_status,
        output logic       o_wr_en,
        output addr_t      o_wr_addr,
        output ptr_jc_t    o_wr_ptr_jc
);

        wr_status_t status_q;
        wr_status_t status_next;
        ptr_bin_t   wr_ptr;
        ptr_bin_t   wr_ptr_next;
        logic       wr_accept;

        // Request while full is dropped here
        assign wr_accept = i_wr_req.req & ~status_q.full;

        afifo_ptr_cnt u_wr_ptr (
                .i_clk      (wr_clk),
                .i_rst_n    (wr_rst_n),
                .i_en       (wr_accept),
                .o_bin      (wr_ptr),
                .o_bin_next (wr_ptr_next),
                .o_jc       (o_wr_ptr_jc)
        );

        // ------------------------------------------------------------
        // Flags against the synchronized read pointer
        // ------------------------------------------------------------
        // Same address one pass apart means every entry is used
        assign status_next.full = (wr_ptr_next.addr == i_rd_ptr.addr) &&
                                  (wr_ptr_next.wrap != i_rd_ptr.wrap);
        assign status_next.almost_full = fill_level(wr_ptr_next, i_rd_ptr) >=
                                         PTR_W'(FIFO_DEPTH - ALMOST_WR_MARGIN);

        always_ff @(posedge wr_clk) begin
                if (!wr_rst_n) begin
                        status_q <= '0;
                end else begin
                        status_q <= status_next;
                end
        end

        assign o_wr_status = status_q;
        assign o_wr_en     = wr_accept;
        // Current pointer addresses the slot being written
        assign o_wr_addr   = wr_ptr.addr;

endmodule

`default_nettype wire

// File: ctrl/afifo_rd_ctrl.sv
// Read-domain controller
// Accepts reads while not empty and drives the storage read port
// Empty and almost-empty are registered from the next read pointer

`default_nettype none

module afifo_rd_ctrl
        import afifo_pkg::*;
(
        input  wire        rd_clk,
        input  wire        rd_rst_n,
        input  wire        i_read,
        input  ptr_bin_t   i_wr_ptr,
        output rd_status_t o_rd_status,
        output logic       o_rd_en,
        output addr_t      o_rd_addr,
        output ptr_jc_t    o_rd_ptr_jc
);

        rd_status_t status_q;
        rd_status_t status_next;
        ptr_bin_t   rd_ptr;
        ptr_bin_t   rd_ptr_next;
        logic       rd_accept;

        // Read while empty is dropped here
        assign rd_accept = i_read & ~status_q.empty;

        afifo_ptr_cnt u_rd_ptr (
                .i_clk      (rd_clk),
                .i_rst_n    (rd_rst_n),
                .i_en       (rd_accept),
                .o_bin      (rd_ptr),
                .o_bin_next (rd_ptr_next),
                .o_jc       (o_rd_ptr_jc)
        );

        // ------------------------------------------------------------
        // Flags against the synchronized write pointer
        // ------------------------------------------------------------
        // Caught up with the writer, wrap included
        assign status_next.empty        = (rd_ptr_next == i_wr_ptr);
        assign status_next.almost_empty = fill_level(i_wr_ptr, rd_ptr_next) <=
                                          PTR_W'(ALMOST_RD_MARGIN);

        // Both flags come out of reset high
        always_ff @(posedge rd_clk) begin
                if (!rd_rst_n) begin
                        status_q <= '1;
                end else begin
                        status_q <= status_next;
                end
        end

        assign o_rd_status = status_q;
        assign o_rd_en     = rd_accept;
        // Current pointer addresses the oldest word
        assign o_rd_addr   = rd_ptr.addr;

endmodule

`default_nettype wire

// File: cdc/afifo_ptr_sync.sv
// Brings a Johnson pointer from the other clock domain into this one
// SYNC_STAGES flops, then a registered decode to a binary pointer
// Output follows a source change by SYNC_STAGES+1 destination cycles

`default_nettype none

module afifo_ptr_sync
        import afifo_pkg::*;
(
        input  wire      i_clk,
        input  wire      i_rst_n,
        input  ptr_jc_t  i_jc,
        output ptr_bin_t o_bin
);

        ptr_jc_t          sync_q [SYNC_STAGES];
        ptr_jc_t          jc_sync;
        logic [PTR_W-1:0] ones;
        ptr_bin_t         bin_dec;
        ptr_bin_t         bin_q;

        // ------------------------------------------------------------
        // Synchronizer chain
        // ------------------------------------------------------------
        // Only one bit moves per step, so a late sample is off by one state
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        for (int i = 0; i < SYNC_STAGES; i++) begin
                                sync_q[i] <= '0;
                        end
                end else begin
                        sync_q[0] <= i_jc;
                        for (int i = 1; i < SYNC_STAGES; i++) begin
                                sync_q[i] <= sync_q[i-1];
                        end
                end
        end

        assign jc_sync = sync_q[SYNC_STAGES-1];

        // ------------------------------------------------------------
        // Johnson to binary
        // ------------------------------------------------------------
        // Top bit low: states 0..FIFO_DEPTH-1, state equals count of ones
        // Top bit high: second pass, ones shrink from FIFO_DEPTH toward 1
        always_comb begin
                ones = '0;
                for (int i = 0; i < JC_W; i++) begin
                        ones = ones + PTR_W'(jc_sync[i]);
                end
                bin_dec.wrap = jc_sync[JC_W-1];
                if (jc_sync[JC_W-1]) begin
                        bin_dec.addr = addr_t'(FIFO_DEPTH - ones);
                end else begin
                        bin_dec.addr = addr_t'(ones);
                end
        end

        // Decode register keeps the adder tree off the flag path
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        bin_q <= '0;
                end else begin
                        bin_q <= bin_dec;
                end
        end

        assign o_bin = bin_q;

endmodule

`default_nettype wire

// File: design/afifo_dp_ram.sv
// Dual-port storage for the FIFO
// Write port on wr_clk, registered read port on rd_clk
// Read data follows the read enable by one rd_clk cycle

`default_nettype none

module afifo_dp_ram
        import afifo_pkg::*;
(
        input  wire   wr_clk,
        input  wire   i_wr_en,
        input  addr_t i_wr_addr,
        input  data_t i_wr_data,
        input  wire   rd_clk,
        input  wire   rd_rst_n,
        input  wire   i_rd_en,
        input  addr_t i_rd_addr,
        output data_t o_rd_data
);

        // FIFO_DEPTH words, addresses never exceed FIFO_DEPTH-1
        data_t mem [FIFO_DEPTH];
        data_t rd_data_q;

        // Write takes effect at the accepting edge
        always_ff @(posedge wr_clk) begin
                if (i_wr_en) begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // Output register holds the last popped word between reads
        always_ff @(posedge rd_clk) begin
                if (!rd_rst_n) begin
                        rd_data_q <= '0;
                end else if (i_rd_en) begin
                        rd_data_q <= mem[i_rd_addr];
                end
        end

        assign o_rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: design/afifo_top.sv
// Top level of the dual-clock FIFO
// Write side on wr_clk, read side on rd_clk, each with its own sync reset
// Pointers cross as Johnson codes and are decoded back to binary on arrival

`default_nettype none

module afifo_top
        import afifo_pkg::*;
(
        input  wire        wr_clk,
        input  wire        wr_rst_n,
        input  wire        rd_clk,
        input  wire        rd_rst_n,
        input  wr_req_t    i_wr_req,
        input  wire        i_read,
        output wr_status_t o_wr_status,
        output data_t      o_rd_data,
        output rd_status_t o_rd_status
);

        // ------------------------------------------------------------
        // Local wires
        // ------------------------------------------------------------
        logic     wr_en;
        addr_t    wr_addr;
        ptr_jc_t  wr_ptr_jc;
        // Read pointer as seen from the write domain
        ptr_bin_t rd_ptr_wdom;

        logic     rd_en;
        addr_t    rd_addr;
        ptr_jc_t  rd_ptr_jc;
        // Write pointer as seen from the read domain
        ptr_bin_t wr_ptr_rdom;

        // Write domain
        afifo_wr_ctrl u_wr_ctrl (
                .wr_clk       (wr_clk),
                .wr_rst_n     (wr_rst_n),
                .i_wr_req     (i_wr_req),
                .i_rd_ptr     (rd_ptr_wdom),
                .o_wr_status  (o_wr_status),
                .o_wr_en      (wr_en),
                .o_wr_addr    (wr_addr),
                .o_wr_ptr_jc  (wr_ptr_jc)
        );

        // Read domain
        afifo_rd_ctrl u_rd_ctrl (
                .rd_clk       (rd_clk),
                .rd_rst_n     (rd_rst_n),
                .i_read       (i_read),
                .i_wr_ptr     (wr_ptr_rdom),
                .o_rd_status  (o_rd_status),
                .o_rd_en      (rd_en),
                .o_rd_addr    (rd_addr),
                .o_rd_ptr_jc  (rd_ptr_jc)
        );

        // Write pointer into rd_clk
        afifo_ptr_sync u_sync_wr_ptr (
                .i_clk   (rd_clk),
                .i_rst_n (rd_rst_n),
                .i_jc    (wr_ptr_jc),
                .o_bin   (wr_ptr_rdom)
        );

        // Read pointer into wr_clk
        afifo_ptr_sync u_sync_rd_ptr (
                .i_clk   (wr_clk),
                .i_rst_n (wr_rst_n),
                .i_jc    (rd_ptr_jc),
                .o_bin   (rd_ptr_wdom)
        );

        afifo_dp_ram u_ram (
                .wr_clk    (wr_clk),
                .i_wr_en   (wr_en),
                .i_wr_addr (wr_addr),
                .i_wr_data (i_wr_req.data),
                .rd_clk    (rd_clk),
                .rd_rst_n  (rd_rst_n),
                .i_rd_en   (rd_en),
                .i_rd_addr (rd_addr),
                .o_rd_data (o_rd_data)
        );

endmodule

`default_nettype wire

// File: tests/afifo_tb.sv
// Directed testbench for the dual-clock FIFO
// Drives both clock domains, keeps a reference queue of accepted words
// and compares popped data, flags and thresholds against it
// Each test is a task and reports one line when it is done

`default_nettype none

module afifo_tb
        import afifo_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int          TIMEOUT_CYCLES = 3000;
        localparam int          STREAM_WORDS   = 40;
        localparam logic [31:0] SEED           = 32'd73365;

        // ------------------------------------------------------------
        // Clocks, resets and DUT
        // ------------------------------------------------------------
        logic       wr_clk = 1'b0;
        logic       rd_clk = 1'b0;
        logic       wr_rst_n;
        logic       rd_rst_n;
        wr_req_t    wr_req;
        logic       rd_read;
        wr_status_t wr_status;
        data_t      rd_data;
        rd_status_t rd_status;

        // 100 ns write clock, 70 ns read clock
        always #50 wr_clk = ~wr_clk;
        always #35 rd_clk = ~rd_clk;

        afifo_top uut (
                .wr_clk      (wr_clk),
                .wr_rst_n    (wr_rst_n),
                .rd_clk      (rd_clk),
                .rd_rst_n    (rd_rst_n),
                .i_wr_req    (wr_req),
                .i_read      (rd_read),
                .o_wr_status (wr_status),
                .o_rd_data   (rd_data),
                .o_rd_status (rd_status)
        );

        // Words accepted on the write side, oldest first
        data_t       ref_q [$];
        // Most recent word taken off the reference queue
        data_t       last_popped;
        logic [31:0] rng;
        logic [31:0] gap_rng;
        int          pass_count  = 0;
        int          fail_count  = 0;
        int          cycle_count = 0;

        // Run limit in wr_clk cycles
        always @(posedge wr_clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("Timeout: tests did not finish within %0d wr_clk cycles",
                                 TIMEOUT_CYCLES);
                        $display("Result: FAILED");
                        $finish;
                end
        end

        // ------------------------------------------------------------
        // Helpers
        // ------------------------------------------------------------
        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x;
                s = s ^ (s << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h",
                                 $time, name, got, exp);
                        fail_count++;
                end else begin
                        pass_count++;
                end
        endtask

        task automatic report_test(input string name, input int fails_before);
                if (fail_count == fails_before) begin
                        $display("[DONE] %s: ok", name);
                end else begin
                        $display("[DONE] %s: %0d failed checks", name,
                                 fail_count - fails_before);
                end
        endtask

        // Present a word and hold it until full is low at the sampling edge
        task automatic write_word(input data_t d);
                @(posedge wr_clk);
                wr_req <= '{req: 1'b1, data: d};
                @(negedge wr_clk);
                while (wr_status.full) begin
                        @(negedge wr_clk);
                end
                // Accepted at the coming rising edge
                ref_q.push_back(d);
        endtask

        task automatic write_idle();
                @(posedge wr_clk);
                wr_req <= '0;
        endtask

        // Request a read, wait for acceptance, then check the popped word
        task automatic read_word();
                data_t exp;
                @(posedge rd_clk);
                rd_read <= 1'b1;
                @(negedge rd_clk);
                while (rd_status.empty) begin
                        @(negedge rd_clk);
                end
                @(posedge rd_clk);
                rd_read <= 1'b0;
                // Data registered at the accepting edge
                @(negedge rd_clk);
                if (ref_q.size() == 0) begin
                        $display("[FAIL] t=%0t a word was read with none expected", $time);
                        fail_count++;
                end else begin
                        exp = ref_q.pop_front();
                        last_popped = exp;
                        check_value("o_rd_data", rd_data, exp);
                end
        endtask

        // Let pointers cross in both directions
        task automatic settle();
                repeat (8) @(negedge wr_clk);
                repeat (8) @(negedge rd_clk);
        endtask

        task automatic drain_fifo(output int n_words);
                n_words = 0;
                @(negedge rd_clk);
                while (!rd_status.empty) begin
                        read_word();
                        n_words++;
                end
        endtask

        // ------------------------------------------------------------
        // Tests
        // ------------------------------------------------------------
        task automatic test_reset_state();
                int fails_before;
                fails_before = fail_count;
                @(negedge wr_clk);
                check_value("full", wr_status.full, 1'b0);
                check_value("almost_full", wr_status.almost_full, 1'b0);
                @(negedge rd_clk);
                check_value("empty", rd_status.empty, 1'b1);
                check_value("almost_empty", rd_status.almost_empty, 1'b1);
                check_value("o_rd_data", rd_data, 8'h00);
                report_test("reset state", fails_before);
        endtask

        task automatic test_fill();
                int fails_before;
                fails_before = fail_count;
                for (int i = 0; i < FIFO_DEPTH; i++) begin
                        rng = xorshift32(rng);
                        write_word(rng[7:0]);
                end
                write_idle();
                // Full shows right after the last accepting edge
                @(negedge wr_clk);
                check_value("full", wr_status.full, 1'b1);
                check_value("almost_full", wr_status.almost_full, 1'b1);
                // One extra request while full, never queued
                rng = xorshift32(rng);
                @(posedge wr_clk);
                wr_req <= '{req: 1'b1, data: rng[7:0]};
                repeat (3) begin
                        @(negedge wr_clk);
                        check_value("full", wr_status.full, 1'b1);
                end
                write_idle();
                report_test("fill", fails_before);
        endtask

        task automatic test_drain();
                int fails_before;
                int n_words;
                fails_before = fail_count;
                settle();
                drain_fifo(n_words);
                check_value("words drained", n_words, FIFO_DEPTH);
                check_value("queue left", ref_q.size(), 0);
                // Nothing more may appear once the crossing is quiet
                settle();
                check_value("empty", rd_status.empty, 1'b1);
                // Read while empty keeps the last popped word
                @(posedge rd_clk);
                rd_read <= 1'b1;
                @(posedge rd_clk);
                rd_read <= 1'b0;
                @(negedge rd_clk);
                check_value("o_rd_data", rd_data, last_popped);
                report_test("drain in order", fails_before);
        endtask

        task automatic test_thresholds();
                int fails_before;
                int level;
                int n_words;
                fails_before = fail_count;
                for (int i = 0; i < FIFO_DEPTH; i++) begin
                        rng = xorshift32(rng);
                        write_word(rng[7:0]);
                        write_idle();
                        settle();
                        level = ref_q.size();
                        check_value("almost_full", wr_status.almost_full,
                                    level >= FIFO_DEPTH - ALMOST_WR_MARGIN);
                        check_value("almost_empty", rd_status.almost_empty,
                                    level <= ALMOST_RD_MARGIN);
                        check_value("full", wr_status.full, level == FIFO_DEPTH);
                        check_value("empty", rd_status.empty, level == 0);
                end
                drain_fifo(n_words);
                check_value("words drained", n_words, FIFO_DEPTH);
                report_test("almost thresholds", fails_before);
        endtask

        // Writer owns rng, reader owns gap_rng
        task automatic stream_writer(input int n_words);
                int gap;
                for (int i = 0; i < n_words; i++) begin
                        rng = xorshift32(rng);
                        gap = rng[9:8];
                        repeat (gap) write_idle();
                        write_word(rng[7:0]);
                end
                write_idle();
        endtask

        task automatic stream_reader(input int n_words);
                int gap;
                for (int i = 0; i < n_words; i++) begin
                        gap_rng = xorshift32(gap_rng);
                        gap = gap_rng[1:0];
                        repeat (gap) @(posedge rd_clk);
                        read_word();
                end
        endtask

        task automatic test_stream();
                int fails_before;
                fails_before = fail_count;
                gap_rng = xorshift32(rng ^ 32'h5555_5555);
                fork
                        stream_writer(STREAM_WORDS);
                        stream_reader(STREAM_WORDS);
                join
                settle();
                check_value("empty", rd_status.empty, 1'b1);
                check_value("queue left", ref_q.size(), 0);
                report_test("concurrent streaming", fails_before);
        endtask

        // ------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------
        initial begin
                wr_rst_n = 1'b0;
                rd_rst_n = 1'b0;
                wr_req   = '0;
                rd_read  = 1'b0;
                rng      = SEED;
                repeat (10) @(posedge wr_clk);
                wr_rst_n <= 1'b1;
                @(posedge rd_clk);
                rd_rst_n <= 1'b1;

                test_reset_state();
                test_fill();
                test_drain();
                test_thresholds();
                test_stream();

                $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
                if (fail_count == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: afifo.f
common/afifo_pkg.sv
ctrl/afifo_ptr_cnt.sv
ctrl/afifo_wr_ctrl.sv
ctrl/afifo_rd_ctrl.sv
cdc/afifo_ptr_sync.sv
design/afifo_dp_ram.sv
design/afifo_top.sv
tests/afifo_tb.sv

// File: Bender.yml
package:
  name: afifo

sources:
  - common/afifo_pkg.sv
  - ctrl/afifo_ptr_cnt.sv
  - ctrl/afifo_wr_ctrl.sv
  - ctrl/afifo_rd_ctrl.sv
  - cdc/afifo_ptr_sync.sv
  - design/afifo_dp_ram.sv
  - design/afifo_top.sv
  - target: simulation
    files:
      - tests/afifo_tb.sv
